//--- Bender.yml
package:
  name: dsp_datapath

sources:
  - constant_pkg.sv
  - dsp_pkg.sv
  - dsp_cfg_if.sv
  - delay_line.sv
  - ffe_slicer.sv
  - channel_error.sv
  - dsp_datapath_top.sv
  - target: simulation
    files:
      - tb_dsp_datapath.sv

//--- channel_error.sv
module channel_error
    import constant_pkg::*;
    import dsp_pkg::*;
#(
    parameter int channel_pipeline_depth = 0
) (
    input  logic        clk,
    input  logic        rst_n_i,
    dsp_cfg_if.chan     cfg,
    input  logic        bits_valid_i,
    input  bit_word_t   bits_i,
    input  code_word_t  aligned_codes_i,
    output logic        error_valid_o,
    output error_word_t error_o
);

    // Tap magnitude can reach 2**(p-1), plus growth for the sum
    localparam int acc_width = est_channel_precision + $clog2(est_channel_depth) + 1;

    bit_word_t                   bit_hist;
    logic [2*channel_width-1:0]  bit_window;
    logic signed [acc_width-1:0] chan_acc [channel_width];
    est_code_t                   rebuilt  [channel_width];
    error_word_t                 err_next;
    logic                        err_valid_q;
    error_word_t                 err_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bit_hist <= '0;
        end else if (bits_valid_i) begin
            bit_hist <= bits_i;
        end
    end

    // Symbol index i-k maps to bit_window[channel_width+i-k]
    assign bit_window = {bits_i, bit_hist};

    // Bit 1 adds the tap, bit 0 subtracts it
    always_comb begin
        for (int i = 0; i < channel_width; i++) begin
            chan_acc[i] = '0;
            for (int k = 0; k < est_channel_depth; k++) begin
                if (bit_window[channel_width+i-k]) begin
                    chan_acc[i] += $signed(cfg.channel_est[i][k]);
                end else begin
                    chan_acc[i] -= $signed(cfg.channel_est[i][k]);
                end
            end
            rebuilt[i] = est_code_t'(chan_acc[i] >>> cfg.channel_shift[i]);
        end
    end

    always_comb begin
        for (int i = 0; i < channel_width; i++) begin
            err_next[i] = error_t'(rebuilt[i]) - error_t'($signed(aligned_codes_i[i]));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            err_valid_q <= 1'b0;
        end else begin
            err_valid_q <= bits_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (bits_valid_i) begin
            err_q <= err_next;
        end
    end

    delay_line #(
        .payload_t (error_word_t),
        .depth     (channel_pipeline_depth)
    ) u_error_pipe (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (err_valid_q),
        .data_i  (err_q),
        .valid_o (error_valid_o),
        .data_o  (error_o)
    );

    // Code delay line at the top must line up with the slicer latency
    codes_known_a: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        bits_valid_i |-> !$isunknown(aligned_codes_i)
    );

endmodule

//--- constant_pkg.sv
package constant_pkg;

    // Lanes per parallel word
    localparam int channel_width = 4;

    // Signed ADC code width
    localparam int code_precision = 8;

    typedef logic signed [code_precision-1:0] code_t;

    // Lane i sits at index i, lane 0 is the oldest sample
    typedef code_t [channel_width-1:0] code_word_t;

    typedef logic [channel_width-1:0] bit_word_t;

endpackage

//--- delay_line.sv
module delay_line #(
    parameter type payload_t = logic,
    parameter int  depth     = 1
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    generate
        if (depth == 0) begin : g_wire
            assign valid_o = valid_i;
            assign data_o  = data_i;
        end else begin : g_regs
            logic     valid_q [depth];
            payload_t data_q  [depth];

            always_ff @(posedge clk) begin
                if (!rst_n_i) begin
                    for (int s = 0; s < depth; s++) begin
                        valid_q[s] <= 1'b0;
                    end
                end else begin
                    valid_q[0] <= valid_i;
                    for (int s = 1; s < depth; s++) begin
                        valid_q[s] <= valid_q[s-1];
                    end
                end
            end

            // Payload only moves along with its valid
            always_ff @(posedge clk) begin
                if (valid_i) begin
                    data_q[0] <= data_i;
                end
                for (int s = 1; s < depth; s++) begin
                    if (valid_q[s-1]) begin
                        data_q[s] <= data_q[s-1];
                    end
                end
            end

            assign valid_o = valid_q[depth-1];
            assign data_o  = data_q[depth-1];
        end
    endgenerate

    valid_known_a: assert property (@(posedge clk) disable iff (!rst_n_i) !$isunknown(valid_o));

endmodule

//--- dsp_cfg_if.sv
interface dsp_cfg_if
    import dsp_pkg::*;
();

    // FFE and slicer settings
    weight_array_t     weights;
    shift_array_t      ffe_shift;
    thresh_array_t     thresh;

    // Channel estimate used to rebuild the codes
    channel_array_t    channel_est;
    chan_shift_array_t channel_shift;

    modport ffe (
        input weights,
        input ffe_shift,
        input thresh
    );

    modport chan (
        input channel_est,
        input channel_shift
    );

endinterface

//--- dsp_datapath_top.sv
module dsp_datapath_top
    import constant_pkg::*;
    import dsp_pkg::*;
#(
    parameter int ffe_pipeline_depth     = 0,
    parameter int channel_pipeline_depth = 0
) (
    input  logic              clk,
    input  logic              rst_n_i,

    input  logic              codes_valid_i,
    input  code_word_t        adc_codes_i,

    input  weight_array_t     weights_i,
    input  shift_array_t      ffe_shift_i,
    input  thresh_array_t     thresh_i,
    input  channel_array_t    channel_est_i,
    input  chan_shift_array_t channel_shift_i,

    output logic              bits_valid_o,
    output bit_word_t         bits_o,

    output logic              error_valid_o,
    output error_word_t       error_o
);

    // Codes wait for the slicer register plus its extra stages
    localparam int code_delay_depth = ffe_pipeline_depth + 1;

    code_word_t aligned_codes;

    dsp_cfg_if u_cfg ();

    assign u_cfg.weights       = weights_i;
    assign u_cfg.ffe_shift     = ffe_shift_i;
    assign u_cfg.thresh        = thresh_i;
    assign u_cfg.channel_est   = channel_est_i;
    assign u_cfg.channel_shift = channel_shift_i;

    ffe_slicer #(
        .ffe_pipeline_depth (ffe_pipeline_depth)
    ) u_ffe_slicer (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .cfg           (u_cfg.ffe),
        .codes_valid_i (codes_valid_i),
        .adc_codes_i   (adc_codes_i),
        .bits_valid_o  (bits_valid_o),
        .bits_o        (bits_o)
    );

    // Valid out matches bits_valid_o, so it is left open
    delay_line #(
        .payload_t (code_word_t),
        .depth     (code_delay_depth)
    ) u_code_delay (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (codes_valid_i),
        .data_i  (adc_codes_i),
        .valid_o (),
        .data_o  (aligned_codes)
    );

    channel_error #(
        .channel_pipeline_depth (channel_pipeline_depth)
    ) u_channel_error (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .cfg             (u_cfg.chan),
        .bits_valid_i    (bits_valid_o),
        .bits_i          (bits_o),
        .aligned_codes_i (aligned_codes),
        .error_valid_o   (error_valid_o),
        .error_o         (error_o)
    );

endmodule

//--- dsp_pkg.sv
package dsp_pkg;

    import constant_pkg::*;

    // FFE
    localparam int ffe_length           = 3;
    localparam int weight_precision     = 8;
    localparam int ffe_shift_precision  = 4;
    localparam int ffe_output_precision = 16;

    // Slicer
    localparam int thresh_precision = 16;

    // Channel filter and error
    localparam int est_channel_depth       = 3;
    localparam int est_channel_precision   = 8;
    localparam int channel_shift_precision = 4;
    localparam int est_code_precision      = 10;
    localparam int est_error_precision     = 11;

    typedef logic signed [weight_precision-1:0]        weight_t;
    typedef logic        [ffe_shift_precision-1:0]     ffe_shift_t;
    typedef logic signed [ffe_output_precision-1:0]    ffe_out_t;
    typedef logic signed [thresh_precision-1:0]        thresh_t;
    typedef logic signed [est_channel_precision-1:0]   est_tap_t;
    typedef logic        [channel_shift_precision-1:0] chan_shift_t;
    typedef logic signed [est_code_precision-1:0]      est_code_t;
    typedef logic signed [est_error_precision-1:0]     error_t;

    // Indexed [lane][tap]
    typedef weight_t [channel_width-1:0][ffe_length-1:0] weight_array_t;

    typedef thresh_t [channel_width-1:0] thresh_array_t;

    typedef ffe_shift_t [channel_width-1:0] shift_array_t;

    typedef chan_shift_t [channel_width-1:0] chan_shift_array_t;

    // Indexed [lane][tap]
    typedef est_tap_t [channel_width-1:0][est_channel_depth-1:0] channel_array_t;

    typedef error_t [channel_width-1:0] error_word_t;

endpackage

//--- ffe_slicer.sv
module ffe_slicer
    import constant_pkg::*;
    import dsp_pkg::*;
#(
    parameter int ffe_pipeline_depth = 0
) (
    input  logic       clk,
    input  logic       rst_n_i,
    dsp_cfg_if.ffe     cfg,
    input  logic       codes_valid_i,
    input  code_word_t adc_codes_i,
    output logic       bits_valid_o,
    output bit_word_t  bits_o
);

    // Full product width plus growth for the tap sum
    localparam int acc_width = code_precision + weight_precision + $clog2(ffe_length);

    code_word_t                  code_hist;
    code_t [2*channel_width-1:0] samples;
    logic signed [acc_width-1:0] ffe_acc [channel_width];
    ffe_out_t                    ffe_eq  [channel_width];
    bit_word_t                   slice_bits;
    logic                        slice_valid_q;
    bit_word_t                   slice_bits_q;

    // Last valid word, idle cycles leave it alone
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            code_hist <= '0;
        end else if (codes_valid_i) begin
            code_hist <= adc_codes_i;
        end
    end

    // Sample index i-k maps to samples[channel_width+i-k]
    assign samples = {adc_codes_i, code_hist};

    always_comb begin
        for (int i = 0; i < channel_width; i++) begin
            ffe_acc[i] = '0;
            for (int k = 0; k < ffe_length; k++) begin
                ffe_acc[i] += $signed(cfg.weights[i][k]) * $signed(samples[channel_width+i-k]);
            end
            ffe_eq[i] = ffe_out_t'(ffe_acc[i] >>> cfg.ffe_shift[i]);
        end
    end

    // Per-lane threshold
    always_comb begin
        for (int i = 0; i < channel_width; i++) begin
            slice_bits[i] = (ffe_eq[i] >= $signed(cfg.thresh[i]));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            slice_valid_q <= 1'b0;
        end else begin
            slice_valid_q <= codes_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (codes_valid_i) begin
            slice_bits_q <= slice_bits;
        end
    end

    delay_line #(
        .payload_t (bit_word_t),
        .depth     (ffe_pipeline_depth)
    ) u_bits_pipe (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (slice_valid_q),
        .data_i  (slice_bits_q),
        .valid_o (bits_valid_o),
        .data_o  (bits_o)
    );

    generate
        for (genvar g = 0; g < channel_width; g++) begin : g_shift_chk
            // Shifted sum must fit the equalized width
            eq_fits_a: assert property (
                @(posedge clk) disable iff (!rst_n_i)
                codes_valid_i |-> (ffe_eq[g] == (ffe_acc[g] >>> cfg.ffe_shift[g]))
            );
        end
    endgenerate

endmodule

//--- tb_dsp_datapath.sv
module tb_dsp_datapath
    import constant_pkg::*;
    import dsp_pkg::*;
();

    localparam int clk_period    = 10;
    localparam int drive_delay   = 1;
    localparam int reset_cycles  = 8;
    localparam int ffe_depth     = 1;
    localparam int chan_depth    = 0;
    localparam int bits_latency  = ffe_depth + 1;
    localparam int error_latency = ffe_depth + chan_depth + 2;
    localparam int drain_limit   = 16;
    localparam int n_pass        = 48;
    localparam int n_ffe         = 64;
    localparam int n_chan        = 64;
    localparam int n_idle        = 64;
    // A word in the idle test takes at most four cycles
    localparam int watchdog_cycles = reset_cycles + 5 + n_pass + n_ffe + n_chan
                                     + 4 * n_idle + 5 * drain_limit + 100;

    logic              clk;
    logic              rst_n;
    logic              codes_valid;
    code_word_t        adc_codes;
    weight_array_t     weights;
    shift_array_t      ffe_shift;
    thresh_array_t     thresh;
    channel_array_t    channel_est;
    chan_shift_array_t channel_shift;
    logic              bits_valid;
    bit_word_t         bits;
    logic              error_valid;
    error_word_t       error_word;

    logic [31:0] lfsr_state;
    int          cyc;
    int          bit_errors  = 0;
    int          err_errors  = 0;
    int          ctrl_errors = 0;

    // Reference model history and expected outputs
    code_word_t  model_codes;
    bit_word_t   model_bits_hist;
    bit_word_t   exp_bits_q [$];
    int          bits_cyc_q [$];
    error_word_t exp_err_q  [$];
    int          err_cyc_q  [$];

    dsp_datapath_top #(
        .ffe_pipeline_depth     (ffe_depth),
        .channel_pipeline_depth (chan_depth)
    ) u_dut (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .codes_valid_i   (codes_valid),
        .adc_codes_i     (adc_codes),
        .weights_i       (weights),
        .ffe_shift_i     (ffe_shift),
        .thresh_i        (thresh),
        .channel_est_i   (channel_est),
        .channel_shift_i (channel_shift),
        .bits_valid_o    (bits_valid),
        .bits_o          (bits),
        .error_valid_o   (error_valid),
        .error_o         (error_word)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    function automatic int rand_signed(input int n);
        int v;
        v = rand_bits(n);
        if (v >= (1 << (n - 1))) begin
            v -= (1 << n);
        end
        return v;
    endfunction

    function automatic code_word_t random_word();
        code_word_t w;
        for (int i = 0; i < channel_width; i++) begin
            w[i] = code_t'(rand_bits(code_precision));
        end
        return w;
    endfunction

    // Sample index i-k below zero reaches into the previous word
    function automatic bit_word_t model_slice(input code_word_t cur, input code_word_t prev);
        bit_word_t b;
        int        acc;
        int        s;
        for (int i = 0; i < channel_width; i++) begin
            acc = 0;
            for (int k = 0; k < ffe_length; k++) begin
                if (i - k >= 0) begin
                    s = $signed(cur[i-k]);
                end else begin
                    s = $signed(prev[channel_width+i-k]);
                end
                acc += int'($signed(weights[i][k])) * s;
            end
            acc = acc >>> ffe_shift[i];
            b[i] = (acc >= int'($signed(thresh[i])));
        end
        return b;
    endfunction

    function automatic error_word_t model_error(input bit_word_t cur, input bit_word_t prev,
                                                input code_word_t codes);
        error_word_t e;
        int          acc;
        logic        sym;
        for (int i = 0; i < channel_width; i++) begin
            acc = 0;
            for (int k = 0; k < est_channel_depth; k++) begin
                sym = (i - k >= 0) ? cur[i-k] : prev[channel_width+i-k];
                if (sym) begin
                    acc += int'($signed(channel_est[i][k]));
                end else begin
                    acc -= int'($signed(channel_est[i][k]));
                end
            end
            acc = acc >>> channel_shift[i];
            e[i] = error_t'(acc - int'($signed(codes[i])));
        end
        return e;
    endfunction

    task automatic drive_word(input code_word_t w, input logic v);
        bit_word_t   b;
        error_word_t e;
        @(posedge clk);
        #drive_delay;
        codes_valid = v;
        adc_codes   = w;
        if (v) begin
            b = model_slice(w, model_codes);
            e = model_error(b, model_bits_hist, w);
            model_codes     = w;
            model_bits_hist = b;
            exp_bits_q.push_back(b);
            bits_cyc_q.push_back(cyc);
            exp_err_q.push_back(e);
            err_cyc_q.push_back(cyc);
        end
    endtask

    // Waits until every outstanding word has come out
    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        #drive_delay;
        codes_valid = 1'b0;
        while ((exp_bits_q.size() != 0 || exp_err_q.size() != 0) && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        if (exp_bits_q.size() != 0 || exp_err_q.size() != 0) begin
            $display("Outputs still missing %0d cycles after the last word", drain_limit);
            ctrl_errors++;
            exp_bits_q.delete();
            bits_cyc_q.delete();
            exp_err_q.delete();
            err_cyc_q.delete();
        end
        #drive_delay;
    endtask

    task automatic check_bits_out();
        bit_word_t exp;
        int        age;
        if (exp_bits_q.size() == 0) begin
            $display("bits_valid_o raised with no word outstanding");
            ctrl_errors++;
        end else begin
            exp = exp_bits_q.pop_front();
            age = cyc - bits_cyc_q.pop_front();
            if (age != bits_latency) begin
                $display("bits_o came %0d cycles after its word instead of %0d",
                         age, bits_latency);
                ctrl_errors++;
            end
            if (bits !== exp) begin
                $display("Mismatch bits_o: expected %h, got %h", exp, bits);
                bit_errors++;
            end
        end
    endtask

    task automatic check_error_out();
        error_word_t exp;
        int          age;
        if (exp_err_q.size() == 0) begin
            $display("error_valid_o raised with no word outstanding");
            ctrl_errors++;
        end else begin
            exp = exp_err_q.pop_front();
            age = cyc - err_cyc_q.pop_front();
            if (age != error_latency) begin
                $display("error_o came %0d cycles after its word instead of %0d",
                         age, error_latency);
                ctrl_errors++;
            end
            if (error_word !== exp) begin
                $display("Mismatch error_o: expected %h, got %h", exp, error_word);
                err_errors++;
            end
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            if (bits_valid !== 1'b0 || error_valid !== 1'b0) begin
                $display("A valid output was not low during reset");
                ctrl_errors++;
            end
        end else begin
            if (bits_valid === 1'b1) begin
                check_bits_out();
            end
            if (error_valid === 1'b1) begin
                check_error_out();
            end
        end
    end

    task automatic set_pass_through();
        weights       = '0;
        ffe_shift     = '0;
        thresh        = '0;
        channel_est   = '0;
        channel_shift = '0;
        for (int i = 0; i < channel_width; i++) begin
            weights[i][0]     = weight_t'(1);
            channel_est[i][0] = est_tap_t'(32);
            channel_est[i][1] = est_tap_t'(8);
        end
    endtask

    task automatic set_multi_tap();
        for (int i = 0; i < channel_width; i++) begin
            for (int k = 0; k < ffe_length; k++) begin
                weights[i][k] = weight_t'(rand_signed(6));
            end
            ffe_shift[i] = ffe_shift_t'(i + 1);
            thresh[i]    = thresh_t'(rand_signed(7));
        end
    endtask

    task automatic set_channel();
        for (int i = 0; i < channel_width; i++) begin
            for (int k = 0; k < est_channel_depth; k++) begin
                channel_est[i][k] = est_tap_t'(rand_signed(est_channel_precision));
            end
            channel_shift[i] = chan_shift_t'(i);
        end
    endtask

    task automatic test_reset();
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        // Nothing may come out before the first valid word
        repeat (4) drive_word(random_word(), 1'b0);
        drive_word(random_word(), 1'b1);
        drain();
    endtask

    task automatic test_pass_through();
        repeat (n_pass) drive_word(random_word(), 1'b1);
        drain();
    endtask

    task automatic test_multi_tap();
        set_multi_tap();
        repeat (n_ffe) drive_word(random_word(), 1'b1);
        drain();
    endtask

    task automatic test_channel_error();
        set_channel();
        repeat (n_chan) drive_word(random_word(), 1'b1);
        drain();
    endtask

    // Garbage codes on idle cycles must not reach the history
    task automatic test_idle_gaps();
        int gap;
        for (int w = 0; w < n_idle; w++) begin
            gap = rand_bits(2);
            repeat (gap) drive_word(random_word(), 1'b0);
            drive_word(random_word(), 1'b1);
        end
        drain();
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Run stopped by the watchdog after %0d cycles", watchdog_cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        codes_valid     = 1'b0;
        adc_codes       = '0;
        cyc             = 0;
        lfsr_state      = 32'h284a1bce;
        model_codes     = '0;
        model_bits_hist = '0;
        set_pass_through();
        test_reset();
        test_pass_through();
        test_multi_tap();
        test_channel_error();
        test_idle_gaps();
        $display("Errors: bits %0d, error words %0d, valid and latency %0d",
                 bit_errors, err_errors, ctrl_errors);
        if (bit_errors + err_errors + ctrl_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
constant_pkg.sv
dsp_pkg.sv
dsp_cfg_if.sv
delay_line.sv
ffe_slicer.sv
channel_error.sv
dsp_datapath_top.sv
tb_dsp_datapath.sv
